// ==== src/cop_isa_pkg.sv ====
// Coprocessor ISA package with the instruction word layout, function codes and result codes
`default_nettype none

package cop_isa_pkg;

    // Packed lane geometry
    localparam int NUM_LANES = 4;
    localparam int LANE_W    = 8;

    // Register form, used by PADD, PSUB, PXOR and the moves
    typedef struct packed {
        logic [3:0]  funct;     // Function code
        logic [3:0]  crd;       // Destination CPR
        logic [3:0]  crs1;      // First source CPR
        logic [3:0]  crs2;      // Second source CPR
        logic [4:0]  rd;        // GPR write-back target
        logic [10:0] reserved;
    } reg_form_t;

    // Immediate form, used by PADDI
    typedef struct packed {
        logic [3:0]  funct;
        logic [3:0]  crd;
        logic [3:0]  crs1;
        logic [7:0]  imm8;      // Replicated into every byte
        logic [4:0]  rd;
        logic [6:0]  reserved;
    } imm_form_t;

    // Same 32 bits, two decodes
    typedef union packed {
        reg_form_t reg_form;
        imm_form_t imm_form;
    } insn_word_u;

    typedef enum logic [3:0] {
        PADD   = 4'd0,
        PSUB   = 4'd1,
        PXOR   = 4'd2,
        PADDI  = 4'd3,
        MV_R2C = 4'd4,  // GPR rs1 into crd
        MV_C2R = 4'd5   // CPR crs1 back to GPR rd
    } funct_e;

    typedef enum logic [1:0] {LANE_ADD, LANE_SUB, LANE_XOR} lane_op_e;

    typedef enum logic [2:0] {RES_OK = 3'd0, RES_ILLEGAL = 3'd1} result_e;

endpackage

`default_nettype wire

// ==== src/cop_trace_pkg.sv ====
// Register file and datapath widths shared by the CPRs, trace capture and testbench
`default_nettype none

package cop_trace_pkg;

    // ------------------------------------------------
    // Coprocessor register file
    localparam int NUM_CPRS = 16;
    localparam int CPR_AW   = 4;    // log2 of NUM_CPRS

    // ------------------------------------------------
    // CPU side
    localparam int XLEN     = 32;   // GPR and RS1 width
    localparam int GPR_AW   = 5;    // 32 GPRs

endpackage

`default_nettype wire

// ==== src/cop_lane.sv ====
// One byte lane of packed add, subtract and xor
`timescale 1ns/1ps
`default_nettype none

module cop_lane (
    input  wire cop_isa_pkg::lane_op_e               op,
    input  wire [cop_isa_pkg::LANE_W-1:0]            a,
    input  wire [cop_isa_pkg::LANE_W-1:0]            b,
    output logic [cop_isa_pkg::LANE_W-1:0]           y
);

    logic [cop_isa_pkg::LANE_W-1:0] sum;
    logic [cop_isa_pkg::LANE_W-1:0] diff;

    // Carry out of the lane is dropped, so results wrap modulo 256
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            cop_isa_pkg::LANE_ADD: y = sum;
            cop_isa_pkg::LANE_SUB: y = diff;
            cop_isa_pkg::LANE_XOR: y = a ^ b;
            default:               y = '0;  // Unused encoding
        endcase
    end

    // ------------------------------------------------
    // Decode must never hand a lane the spare encoding
    always_comb begin
        assert ($isunknown(op) || op inside {
            cop_isa_pkg::LANE_ADD,
            cop_isa_pkg::LANE_SUB,
            cop_isa_pkg::LANE_XOR
        })
        else $error("cop_lane: op %0d outside lane_op_e", op);
    end

endmodule

`default_nettype wire

// ==== src/cop_decode.sv ====
// Instruction decoder, picks the word form and steers the lane operands
`timescale 1ns/1ps
`default_nettype none

module cop_decode (
    input  wire cop_isa_pkg::insn_word_u              insn,         // Held instruction word
    input  wire [cop_trace_pkg::XLEN-1:0]             cpr_rs1_data, // CPR crs1 value
    input  wire [cop_trace_pkg::XLEN-1:0]             cpr_rs2_data, // CPR crs2 value
    output logic [cop_trace_pkg::CPR_AW-1:0]          cpr_ra,
    output logic [cop_trace_pkg::CPR_AW-1:0]          cpr_rb,
    output cop_isa_pkg::lane_op_e                     lane_op,
    output logic [cop_trace_pkg::XLEN-1:0]            lane_a,
    output logic [cop_trace_pkg::XLEN-1:0]            lane_b,
    output logic                                      illegal
);

    cop_isa_pkg::funct_e funct;

    // Funct sits in the same bits in both forms
    assign funct = cop_isa_pkg::funct_e'(insn.reg_form.funct);

    // crs1 shares its slot too; crs2 is only meaningful in register form
    assign cpr_ra = insn.reg_form.crs1;
    assign cpr_rb = insn.reg_form.crs2;
    assign lane_a = cpr_rs1_data;

    // ------------------------------------------------
    // Function decode
    always_comb begin
        lane_op = cop_isa_pkg::LANE_ADD;
        lane_b  = cpr_rs2_data;         // Register form by default
        illegal = 1'b0;
        case (funct)
            cop_isa_pkg::PADD: begin
                lane_op = cop_isa_pkg::LANE_ADD;
            end
            cop_isa_pkg::PSUB: begin
                lane_op = cop_isa_pkg::LANE_SUB;
            end
            cop_isa_pkg::PXOR: begin
                lane_op = cop_isa_pkg::LANE_XOR;
            end
            cop_isa_pkg::PADDI: begin
                // Immediate view of the word, imm8 into every byte
                lane_op = cop_isa_pkg::LANE_ADD;
                lane_b  = {cop_isa_pkg::NUM_LANES{insn.imm_form.imm8}};
            end
            cop_isa_pkg::MV_R2C, cop_isa_pkg::MV_C2R: begin
                lane_op = cop_isa_pkg::LANE_ADD; // Lanes unused
            end
            default: begin
                illegal = 1'b1;         // Codes 6 to 15
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cop_cprs.sv ====
// Coprocessor register file, two read ports, one write port and a snoop port
`timescale 1ns/1ps
`default_nettype none

module cop_cprs (
    input  wire                                g_clk,
    input  wire                                g_resetn,
    input  wire [cop_trace_pkg::CPR_AW-1:0]    ra,         // Read port A address
    input  wire [cop_trace_pkg::CPR_AW-1:0]    rb,         // Read port B address
    output logic [cop_trace_pkg::XLEN-1:0]     rdata_a,
    output logic [cop_trace_pkg::XLEN-1:0]     rdata_b,
    input  wire                                wen,
    input  wire [cop_trace_pkg::CPR_AW-1:0]    waddr,
    input  wire [cop_trace_pkg::XLEN-1:0]      wdata,
    input  wire [cop_trace_pkg::CPR_AW-1:0]    snoop_addr, // Trace-only read
    output logic [cop_trace_pkg::XLEN-1:0]     snoop_data
);

    logic [cop_trace_pkg::XLEN-1:0] regs [cop_trace_pkg::NUM_CPRS];

    // ------------------------------------------------
    // Write port, all registers start at zero
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < cop_trace_pkg::NUM_CPRS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata_a    = regs[ra];
    assign rdata_b    = regs[rb];
    assign snoop_data = regs[snoop_addr];   // Kept off the datapath ports

endmodule

`default_nettype wire

// ==== src/cop_issue_ctrl.sv ====
// Issue sequencer for both four-phase handshakes, merges lane results and commits writes
`timescale 1ns/1ps
`default_nettype none

module cop_issue_ctrl (
    input  wire                                g_clk,
    input  wire                                g_resetn,
    input  wire                                cpu_insn_req,
    input  wire [31:0]                         cpu_insn_enc,
    input  wire [cop_trace_pkg::XLEN-1:0]      cpu_rs1,
    output logic                               cop_insn_ack,
    output logic                               cop_insn_rsp,
    input  wire                                cpu_insn_ack,
    output cop_isa_pkg::result_e               cop_result,
    output logic                               cop_wen,    // GPR write-back
    output logic [cop_trace_pkg::GPR_AW-1:0]   cop_waddr,
    output logic [cop_trace_pkg::XLEN-1:0]     cop_wdata,
    output cop_isa_pkg::insn_word_u            insn,       // Held word for decode
    input  wire                                illegal,
    input  wire [cop_trace_pkg::XLEN-1:0]      lane_y,     // Merged lane bytes
    input  wire [cop_trace_pkg::XLEN-1:0]      cpr_rdata_a,
    output logic                               cpr_wen,
    output logic [cop_trace_pkg::CPR_AW-1:0]   cpr_waddr,
    output logic [cop_trace_pkg::XLEN-1:0]     cpr_wdata
);

    typedef enum logic [2:0] {S_IDLE, S_ACK, S_EXEC, S_RESP, S_REL} state_e;

    state_e                         state;
    logic [cop_trace_pkg::XLEN-1:0] rs1_q;
    cop_isa_pkg::funct_e            funct;
    logic                           is_c2r;

    assign funct  = cop_isa_pkg::funct_e'(insn.reg_form.funct);
    assign is_c2r = (funct == cop_isa_pkg::MV_C2R);

    // ------------------------------------------------
    // Sequencer
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (cpu_insn_req)  state <= S_ACK;
                S_ACK:  if (!cpu_insn_req) state <= S_EXEC;
                S_EXEC:                    state <= S_RESP;  // Always one cycle
                S_RESP: if (cpu_insn_ack)  state <= S_REL;
                S_REL:  if (!cpu_insn_ack) state <= S_IDLE;
                default:                   state <= S_IDLE;
            endcase
        end
    end

    assign cop_insn_ack = (state == S_ACK);
    assign cop_insn_rsp = (state == S_RESP);

    // Capture the request while idle; CPU holds it stable
    always_ff @(posedge g_clk) begin
        if (state == S_IDLE && cpu_insn_req) begin
            insn  <= cpu_insn_enc;
            rs1_q <= cpu_rs1;
        end
    end

    // CPR write lands in the execute cycle
    assign cpr_wen   = (state == S_EXEC) && !illegal && !is_c2r;
    assign cpr_waddr = insn.reg_form.crd;
    assign cpr_wdata = (funct == cop_isa_pkg::MV_R2C) ? rs1_q : lane_y;

    // Response fields, loaded once and held through back-pressure
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            cop_wen <= 1'b0;
        end else if (state == S_EXEC) begin
            cop_wen <= is_c2r;
        end
    end

    always_ff @(posedge g_clk) begin
        if (state == S_EXEC) begin
            cop_result <= illegal ? cop_isa_pkg::RES_ILLEGAL : cop_isa_pkg::RES_OK;
            cop_waddr  <= is_c2r ? insn.reg_form.rd : '0;
            cop_wdata  <= is_c2r ? cpr_rdata_a : '0;
        end
    end

    // ------------------------------------------------
    // Handshake checks
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_rsp && cop_insn_ack));

    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp &&
        $stable({cop_result, cop_wen, cop_waddr, cop_wdata}));

endmodule

`default_nettype wire

// ==== src/cop_trace_capture.sv ====
// Trace capture, records issue and completion views and emits one record per instruction
`timescale 1ns/1ps
`default_nettype none

module cop_trace_capture (
    input  wire                                g_clk,
    input  wire                                g_resetn,
    input  wire                                cpu_insn_req,
    input  wire                                cop_insn_ack,
    input  wire                                cop_insn_rsp,
    input  wire                                cpu_insn_ack,
    input  wire [31:0]                         cpu_insn_enc,
    input  wire [cop_trace_pkg::XLEN-1:0]      cpu_rs1,
    input  wire cop_isa_pkg::result_e          cop_result,
    input  wire                                cop_wen,
    input  wire [cop_trace_pkg::GPR_AW-1:0]    cop_waddr,
    input  wire [cop_trace_pkg::XLEN-1:0]      cop_wdata,
    output logic [cop_trace_pkg::CPR_AW-1:0]   snoop_addr,
    input  wire [cop_trace_pkg::XLEN-1:0]      snoop_data,
    output logic                               trace_valid,    // One-cycle pulse
    output logic [31:0]                        trace_enc,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_rs1,
    output cop_isa_pkg::result_e               trace_result,
    output logic                               trace_wen,
    output logic [cop_trace_pkg::GPR_AW-1:0]   trace_waddr,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_wdata,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_crd_pre,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_crd_post
);

    cop_isa_pkg::insn_word_u        enc_in;
    cop_isa_pkg::insn_word_u        enc_q;      // Own copy of the word
    logic [cop_trace_pkg::XLEN-1:0] rs1_q;
    logic [cop_trace_pkg::XLEN-1:0] crd_pre_q;
    logic                           issue_edge;
    logic                           done_edge;

    assign enc_in     = cpu_insn_enc;
    assign issue_edge = cpu_insn_req && cop_insn_ack;
    assign done_edge  = cop_insn_rsp && cpu_insn_ack;

    // Live encoding during issue, stored copy afterwards
    assign snoop_addr = issue_edge ? enc_in.reg_form.crd : enc_q.reg_form.crd;

    // ------------------------------------------------
    // Issue side
    always_ff @(posedge g_clk) begin
        if (issue_edge) begin
            enc_q     <= enc_in;
            rs1_q     <= cpu_rs1;
            crd_pre_q <= snoop_data;    // CPR not yet written
        end
    end

    // ------------------------------------------------
    // Completion side
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= done_edge;
        end
    end

    always_ff @(posedge g_clk) begin
        if (done_edge) begin
            trace_enc      <= enc_q;
            trace_rs1      <= rs1_q;
            trace_result   <= cop_result;
            trace_wen      <= cop_wen;
            trace_waddr    <= cop_waddr;
            trace_wdata    <= cop_wdata;
            trace_crd_pre  <= crd_pre_q;
            trace_crd_post <= snoop_data;   // Write already committed in execute
        end
    end

    // Sequencer must drop rsp straight after the ack it sees
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        trace_valid |=> !trace_valid);

endmodule

`default_nettype wire

// ==== src/cop_top.sv ====
// Crypto coprocessor top level joining decode, byte lanes, CPRs, sequencer and trace
`timescale 1ns/1ps
`default_nettype none

module cop_top (
    input  wire                                g_clk,
    input  wire                                g_resetn,
    input  wire                                cpu_insn_req,
    input  wire [31:0]                         cpu_insn_enc,
    input  wire [cop_trace_pkg::XLEN-1:0]      cpu_rs1,
    output logic                               cop_insn_ack,
    output logic                               cop_insn_rsp,
    input  wire                                cpu_insn_ack,
    output cop_isa_pkg::result_e               cop_result,
    output logic                               cop_wen,
    output logic [cop_trace_pkg::GPR_AW-1:0]   cop_waddr,
    output logic [cop_trace_pkg::XLEN-1:0]     cop_wdata,
    output logic                               trace_valid,
    output logic [31:0]                        trace_enc,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_rs1,
    output cop_isa_pkg::result_e               trace_result,
    output logic                               trace_wen,
    output logic [cop_trace_pkg::GPR_AW-1:0]   trace_waddr,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_wdata,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_crd_pre,
    output logic [cop_trace_pkg::XLEN-1:0]     trace_crd_post
);

    cop_isa_pkg::insn_word_u                insn;
    cop_isa_pkg::lane_op_e                  lane_op;
    logic [cop_trace_pkg::XLEN-1:0]         lane_a, lane_b, lane_y;
    logic [cop_trace_pkg::CPR_AW-1:0]       cpr_ra, cpr_rb, cpr_waddr, snoop_addr;
    logic [cop_trace_pkg::XLEN-1:0]         rdata_a, rdata_b, cpr_wdata, snoop_data;
    logic                                   cpr_wen;
    logic                                   illegal;

    cop_decode u_decode (
        .insn(insn), .cpr_rs1_data(rdata_a), .cpr_rs2_data(rdata_b),
        .cpr_ra(cpr_ra), .cpr_rb(cpr_rb), .lane_op(lane_op),
        .lane_a(lane_a), .lane_b(lane_b), .illegal(illegal)
    );

    // ------------------------------------------------
    // Byte lanes, no carry between them
    for (genvar i = 0; i < cop_isa_pkg::NUM_LANES; i++) begin : g_lane
        cop_lane u_lane (
            .op(lane_op),
            .a (lane_a[i*cop_isa_pkg::LANE_W +: cop_isa_pkg::LANE_W]),
            .b (lane_b[i*cop_isa_pkg::LANE_W +: cop_isa_pkg::LANE_W]),
            .y (lane_y[i*cop_isa_pkg::LANE_W +: cop_isa_pkg::LANE_W])
        );
    end

    cop_cprs u_cprs (
        .g_clk(g_clk), .g_resetn(g_resetn), .ra(cpr_ra), .rb(cpr_rb),
        .rdata_a(rdata_a), .rdata_b(rdata_b), .wen(cpr_wen), .waddr(cpr_waddr),
        .wdata(cpr_wdata), .snoop_addr(snoop_addr), .snoop_data(snoop_data)
    );

    cop_issue_ctrl u_ctrl (
        .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1), .cop_insn_ack(cop_insn_ack),
        .cop_insn_rsp(cop_insn_rsp), .cpu_insn_ack(cpu_insn_ack),
        .cop_result(cop_result), .cop_wen(cop_wen), .cop_waddr(cop_waddr),
        .cop_wdata(cop_wdata), .insn(insn), .illegal(illegal), .lane_y(lane_y),
        .cpr_rdata_a(rdata_a), .cpr_wen(cpr_wen), .cpr_waddr(cpr_waddr),
        .cpr_wdata(cpr_wdata)
    );

    // Watches the same ports the CPU sees
    cop_trace_capture u_trace (
        .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
        .cop_insn_ack(cop_insn_ack), .cop_insn_rsp(cop_insn_rsp),
        .cpu_insn_ack(cpu_insn_ack), .cpu_insn_enc(cpu_insn_enc), .cpu_rs1(cpu_rs1),
        .cop_result(cop_result), .cop_wen(cop_wen), .cop_waddr(cop_waddr),
        .cop_wdata(cop_wdata), .snoop_addr(snoop_addr), .snoop_data(snoop_data),
        .trace_valid(trace_valid), .trace_enc(trace_enc), .trace_rs1(trace_rs1),
        .trace_result(trace_result), .trace_wen(trace_wen),
        .trace_waddr(trace_waddr), .trace_wdata(trace_wdata),
        .trace_crd_pre(trace_crd_pre), .trace_crd_post(trace_crd_post)
    );

endmodule

`default_nettype wire

// ==== include/cop_vectors.svh ====
// Coprocessor instruction vectors with expected response and trace values
`ifndef COP_VECTORS_SVH
`define COP_VECTORS_SVH

    localparam int N_VEC = 20;

    // Columns: encoding, rs1, result, GPR wen, GPR waddr, GPR wdata, crd before, crd after
    task automatic load_vectors();
        // Fresh CPRs read back zero
        add_vec(c2r(4'h3, 5'd7), 'h0, OK, 1'b1, 5'd7, 'h0, 'h0, 'h0);
        add_vec(r2c(4'h1), 'h11223344, OK, 1'b0, 5'd0, 'h0, 'h0, 'h11223344);
        add_vec(c2r(4'h1, 5'd5), 'h0, OK, 1'b1, 5'd5, 'h11223344, 'h11223344, 'h11223344);
        add_vec(r2c(4'h2), 'hF0E0D0C0, OK, 1'b0, 5'd0, 'h0, 'h0, 'hF0E0D0C0);
        // Byte lanes wrap on their own
        add_vec(reg_insn(PADD, 4'h3, 4'h1, 4'h2), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'h01020304);
        add_vec(c2r(4'h3, 5'd10), 'h0, OK, 1'b1, 5'd10, 'h01020304, 'h01020304, 'h01020304);
        add_vec(reg_insn(PSUB, 4'h4, 4'h1, 4'h2), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'h21426384);
        add_vec(c2r(4'h4, 5'd31), 'h0, OK, 1'b1, 5'd31, 'h21426384, 'h21426384, 'h21426384);
        add_vec(reg_insn(PXOR, 4'h5, 4'h1, 4'h2), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'hE1C2E384);
        add_vec(c2r(4'h5, 5'd1), 'h0, OK, 1'b1, 5'd1, 'hE1C2E384, 'hE1C2E384, 'hE1C2E384);
        // Register view of these bits is crs2 = 4'hF, which still reads zero
        add_vec(imm_insn(4'h6, 4'h1, 8'hF0), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'h01122334);
        add_vec(c2r(4'h6, 5'd2), 'h0, OK, 1'b1, 5'd2, 'h01122334, 'h01122334, 'h01122334);
        // Illegal codes, CPRs untouched
        add_vec(reg_insn(4'h6, 4'h1, 4'h1, 4'h2), 'h5A, ILL, 1'b0, 5'd0, 'h0, 'h11223344, 'h11223344);
        add_vec(reg_insn(4'hF, 4'h3, 4'h1, 4'h2), 'hA5, ILL, 1'b0, 5'd0, 'h0, 'h01020304, 'h01020304);
        add_vec(c2r(4'h1, 5'd4), 'h0, OK, 1'b1, 5'd4, 'h11223344, 'h11223344, 'h11223344);
        // Carry and borrow stop at the byte edge
        add_vec(r2c(4'h7), 'hFFFFFFFF, OK, 1'b0, 5'd0, 'h0, 'h0, 'hFFFFFFFF);
        add_vec(imm_insn(4'h8, 4'h7, 8'h02), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'h01010101);
        add_vec(reg_insn(PSUB, 4'h9, 4'h8, 4'h7), 'h0, OK, 1'b0, 5'd0, 'h0, 'h0, 'h02020202);
        add_vec(c2r(4'h9, 5'd12), 'h0, OK, 1'b1, 5'd12, 'h02020202, 'h02020202, 'h02020202);
        // Destination doubles as both sources
        add_vec(reg_insn(PADD, 4'h1, 4'h1, 4'h1), 'h0, OK, 1'b0, 5'd0, 'h0, 'h11223344, 'h22446688);
        if (vec_count != N_VEC) begin
            $display("Vector table holds %0d rows, expected %0d", vec_count, N_VEC);
            abort_run();
        end
    endtask

`endif

// ==== tests/tb_cop_top.sv ====
// Coprocessor testbench driving both four-phase handshakes from a vector table and checking trace
`timescale 1ns/1ps
`default_nettype none

module tb_cop_top;

    localparam int CLK_PERIOD = 40;

    // One table row with issue values and every expected response
    typedef struct {
        logic [31:0]                      enc;
        logic [cop_trace_pkg::XLEN-1:0]   rs1;
        cop_isa_pkg::result_e             result;
        logic                             wen;
        logic [cop_trace_pkg::GPR_AW-1:0] waddr;
        logic [cop_trace_pkg::XLEN-1:0]   wdata, crd_pre, crd_post;
    } vec_t;

    // Short names for the table
    localparam logic [3:0] PADD = cop_isa_pkg::PADD;
    localparam logic [3:0] PSUB = cop_isa_pkg::PSUB;
    localparam logic [3:0] PXOR = cop_isa_pkg::PXOR;
    localparam cop_isa_pkg::result_e OK  = cop_isa_pkg::RES_OK;
    localparam cop_isa_pkg::result_e ILL = cop_isa_pkg::RES_ILLEGAL;

    int     vec_count   = 0;    // Rows loaded so far

`include "cop_vectors.svh"

    logic                             g_clk, g_resetn;
    logic                             cpu_insn_req, cpu_insn_ack;
    logic [31:0]                      cpu_insn_enc, trace_enc;
    logic [cop_trace_pkg::XLEN-1:0]   cpu_rs1, cop_wdata, trace_rs1, trace_wdata;
    logic [cop_trace_pkg::XLEN-1:0]   trace_crd_pre, trace_crd_post;
    logic                             cop_insn_ack, cop_insn_rsp, cop_wen, trace_valid, trace_wen;
    logic [cop_trace_pkg::GPR_AW-1:0] cop_waddr, trace_waddr;
    cop_isa_pkg::result_e             cop_result, trace_result;

    vec_t   vecs [N_VEC];
    int     trace_count = 0;    // Pulses seen so far
    integer seed;

    cop_top dut_i (.*);

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // --------------------------------------------------
    // Encoders for the instruction word fields
    function automatic logic [31:0] reg_insn(input logic [3:0] funct, input logic [3:0] crd,
            input logic [3:0] crs1, input logic [3:0] crs2);
        return {funct, crd, crs1, crs2, 16'h0000};     // rd and reserved zero
    endfunction

    function automatic logic [31:0] imm_insn(input logic [3:0] crd, input logic [3:0] crs1,
            input logic [7:0] imm8);
        return {cop_isa_pkg::PADDI, crd, crs1, imm8, 12'h000};
    endfunction

    function automatic logic [31:0] r2c(input logic [3:0] crd);
        return reg_insn(cop_isa_pkg::MV_R2C, crd, 4'h0, 4'h0);
    endfunction

    // crd mirrors crs1 so the trace shows the source register
    function automatic logic [31:0] c2r(input logic [3:0] crs, input logic [4:0] rd);
        return {cop_isa_pkg::MV_C2R, crs, crs, 4'h0, rd, 11'h000};
    endfunction

    task automatic add_vec(input logic [31:0] enc, input logic [31:0] rs1,
            input cop_isa_pkg::result_e result, input logic wen,
            input logic [cop_trace_pkg::GPR_AW-1:0] waddr, input logic [31:0] wdata,
            input logic [31:0] crd_pre, input logic [31:0] crd_post);
        vecs[vec_count] = '{enc, rs1, result, wen, waddr, wdata, crd_pre, crd_post};
        vec_count++;
    endtask

    // --------------------------------------------------
    // Compare tasks
    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input cop_isa_pkg::result_e got,
            input cop_isa_pkg::result_e exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input logic [cop_trace_pkg::GPR_AW-1:0] got,
            input logic [cop_trace_pkg::GPR_AW-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%02h, expected 0x%02h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_response(input int i);
        check_flag("cop_insn_rsp", cop_insn_rsp, 1'b1);
        check_result("cop_result", cop_result, vecs[i].result);
        check_flag("cop_wen", cop_wen, vecs[i].wen);
        check_addr("cop_waddr", cop_waddr, vecs[i].waddr);
        check_word("cop_wdata", cop_wdata, vecs[i].wdata);
    endtask

    task automatic check_trace(input int i);
        check_word("trace_enc", trace_enc, vecs[i].enc);
        check_word("trace_rs1", trace_rs1, vecs[i].rs1);
        check_result("trace_result", trace_result, vecs[i].result);
        check_flag("trace_wen", trace_wen, vecs[i].wen);
        check_addr("trace_waddr", trace_waddr, vecs[i].waddr);
        check_word("trace_wdata", trace_wdata, vecs[i].wdata);
        check_word("trace_crd_pre", trace_crd_pre, vecs[i].crd_pre);
        check_word("trace_crd_post", trace_crd_post, vecs[i].crd_post);
    endtask

    // --------------------------------------------------
    // One instruction through both handshakes
    task automatic run_insn(input int i);
        int hold;
        @(posedge g_clk);
        cpu_insn_enc <= vecs[i].enc;
        cpu_rs1      <= vecs[i].rs1;
        cpu_insn_req <= 1'b1;
        @(posedge g_clk);
        while (!cop_insn_ack) @(posedge g_clk);
        cpu_insn_req <= 1'b0;               // Ack must follow req down
        @(posedge g_clk);
        while (cop_insn_ack) @(posedge g_clk);
        @(posedge g_clk);
        while (!cop_insn_rsp) @(posedge g_clk);
        hold = $random(seed) & 3;           // 0 to 3 cycles of back-pressure
        check_response(i);
        repeat (hold) begin
            @(posedge g_clk);
            check_response(i);              // Fields hold while stalled
        end
        cpu_insn_ack <= 1'b1;
        @(posedge g_clk);
        while (cop_insn_rsp) @(posedge g_clk);
        cpu_insn_ack <= 1'b0;
    endtask

    // Trace monitor consuming rows in issue order
    always @(posedge g_clk) begin
        if (g_resetn && trace_valid) begin
            if (trace_count >= N_VEC) begin
                $display("Trace pulse seen with no instruction left in the table");
                abort_run();
            end else begin
                check_trace(trace_count);
                trace_count <= trace_count + 1;
            end
        end
    end

    initial begin
        seed         = 32'heed0_0cc8;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        load_vectors();
        repeat (5) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);
        check_flag("cop_insn_ack", cop_insn_ack, 1'b0);   // Idle after reset
        check_flag("cop_insn_rsp", cop_insn_rsp, 1'b0);
        check_flag("cop_wen", cop_wen, 1'b0);
        check_flag("trace_valid", trace_valid, 1'b0);
        for (int i = 0; i < N_VEC; i++) begin
            run_insn(i);
        end
        repeat (3) @(posedge g_clk);        // Last pulse lands one cycle after rsp drops
        if (trace_count != N_VEC) begin
            $display("Saw %0d trace pulses for %0d instructions", trace_count, N_VEC);
            abort_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // Watchdog allowing 20 cycles per table row
    initial begin
        #(N_VEC * 20 * CLK_PERIOD);
        $display("Watchdog expired before the vector table finished");
        abort_run();
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
src/cop_isa_pkg.sv
src/cop_trace_pkg.sv
src/cop_lane.sv
src/cop_decode.sv
src/cop_cprs.sv
src/cop_issue_ctrl.sv
src/cop_trace_capture.sv
src/cop_top.sv
tests/tb_cop_top.sv

// ==== Makefile ====
# Verilator build and run for the coprocessor testbench
TOOL   := verilator
FLAGS  := --binary --timing --assert
TOP    := tb_cop_top
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# Pass only if the log holds the pass line
run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
